//--- verilog/mac_core_pkg.sv
//////////////////////////////////////////////////
// Shared widths, buffer depth and major opcodes
// Enums for ALU ops, operand selects and ID FSM
//////////////////////////////////////////////////

package mac_core_pkg;

  //////////////////////////////////////////////////
  // Widths and depths
  //////////////////////////////////////////////////

  // Data path width
  localparam int unsigned XLEN            = 32;
  // Register address width and count
  localparam int unsigned REG_ADDR_W      = 5;
  localparam int unsigned NUM_REGS        = 32;
  // Buffer entries, also the credits upstream starts with
  localparam int unsigned INSTR_BUF_DEPTH = 4;
  localparam int unsigned INSTR_BUF_PTR_W = 2;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////

  // Major opcodes of the kept RV32 subset
  typedef enum logic [6:0] {
    OPC_OP      = 7'h33,
    OPC_OP_IMM  = 7'h13,
    OPC_LUI     = 7'h37,
    // custom-0 slot carries the MAC instruction
    OPC_CUSTOM0 = 7'h0b
  } opcode_e;

  // ALU operations
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_MUL
  } alu_op_e;

  // Operand A source, zero is for LUI
  typedef enum logic {
    OP_A_REG_A,
    OP_A_ZERO
  } op_a_sel_e;

  // Operand B source
  typedef enum logic [1:0] {
    OP_B_REG_B,
    OP_B_IMM,
    OP_B_PRODUCT
  } op_b_sel_e;

  // ID FSM, second cycle only used by MAC
  typedef enum logic {
    FIRST_CYCLE,
    SECOND_CYCLE
  } id_fsm_e;

endpackage

//--- verilog/alu.sv
//////////////////////////////////////////////////
// Combinational ALU, 32-bit wraparound results
//////////////////////////////////////////////////

`timescale 1ns/1ps

module alu (
  input  mac_core_pkg::alu_op_e         operator_i,
  input  logic [mac_core_pkg::XLEN-1:0] operand_a_i,
  input  logic [mac_core_pkg::XLEN-1:0] operand_b_i,
  output logic [mac_core_pkg::XLEN-1:0] result_o
);

  import mac_core_pkg::*;

  // Full product, only the low word is kept
  logic [2*XLEN-1:0] product;

  assign product = operand_a_i * operand_b_i;

  always_comb begin
    case (operator_i)
      ALU_ADD: result_o = operand_a_i + operand_b_i;
      ALU_SUB: result_o = operand_a_i - operand_b_i;
      ALU_AND: result_o = operand_a_i & operand_b_i;
      ALU_OR:  result_o = operand_a_i | operand_b_i;
      ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      ALU_MUL: result_o = product[XLEN-1:0];
      default: result_o = operand_a_i + operand_b_i;
    endcase
  end

endmodule

//--- verilog/register_file.sv
//////////////////////////////////////////////////
// 32 x 32 register file, two reads, one write
// x0 reads zero and ignores writes
//////////////////////////////////////////////////

`timescale 1ns/1ps

module register_file (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic [mac_core_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [mac_core_pkg::REG_ADDR_W-1:0] raddr_b_i,
  input  logic [mac_core_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [mac_core_pkg::XLEN-1:0]       wdata_i,
  input  logic                                we_i,
  output logic [mac_core_pkg::XLEN-1:0]       rdata_a_o,
  output logic [mac_core_pkg::XLEN-1:0]       rdata_b_o
);

  import mac_core_pkg::*;

  logic [XLEN-1:0] regs_q [NUM_REGS];

  // Entry 0 is never written and stays at its reset zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Asynchronous reads, x0 forced to zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

//--- verilog/instr_buffer.sv
//////////////////////////////////////////////////
// Credit-controlled instruction FIFO
// One credit goes back per retired instruction
//////////////////////////////////////////////////

`timescale 1ns/1ps

module instr_buffer (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            push_i,
  input  logic [mac_core_pkg::XLEN-1:0]   push_instr_i,
  input  logic                            pop_i,
  output logic                            head_valid_o,
  output logic [mac_core_pkg::XLEN-1:0]   head_instr_o,
  output logic                            credit_o
);

  import mac_core_pkg::*;

  // Storage and pointers
  logic [XLEN-1:0]            mem_q [INSTR_BUF_DEPTH];
  logic [INSTR_BUF_PTR_W-1:0] wr_ptr_q;
  logic [INSTR_BUF_PTR_W-1:0] rd_ptr_q;
  // Count needs one more bit than the pointers to hold a full buffer
  logic [INSTR_BUF_PTR_W:0]   count_q;
  logic                       pop_ok;

  assign head_valid_o = (count_q != '0);
  assign head_instr_o = mem_q[rd_ptr_q];

  // Pop only counts when something sits at the head
  assign pop_ok   = pop_i & head_valid_o;
  assign credit_o = pop_ok;

  //////////////////////////////////////////////////
  // Pointer and count update
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Pointers wrap on their own since depth is a power of two
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Sender holds a credit per push so count stays in range
      case ({push_i, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_instr_i;
    end
  end

endmodule

//--- verilog/id_decoder.sv
//////////////////////////////////////////////////
// Decoder for ADD/SUB/AND/OR/XOR/MUL, ADDI, LUI
// and the custom-0 MAC, with illegal flag
//////////////////////////////////////////////////

`timescale 1ns/1ps

module id_decoder (
  input  logic                                head_valid_i,
  input  logic [mac_core_pkg::XLEN-1:0]       instr_i,
  output logic [mac_core_pkg::REG_ADDR_W-1:0] raddr_a_o,
  output logic [mac_core_pkg::REG_ADDR_W-1:0] raddr_b_o,
  output logic [mac_core_pkg::REG_ADDR_W-1:0] waddr_o,
  output logic [mac_core_pkg::XLEN-1:0]       imm_o,
  output mac_core_pkg::alu_op_e               alu_op_o,
  output mac_core_pkg::op_a_sel_e             op_a_sel_o,
  output mac_core_pkg::op_b_sel_e             op_b_sel_o,
  output logic                                rf_we_o,
  output logic                                mac_en_o,
  output logic                                illegal_o
);

  import mac_core_pkg::*;

  // Instruction fields
  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i_type;
  logic [XLEN-1:0] imm_u_type;

  // Raw decode, before head qualification
  alu_op_e         alu_op;
  op_a_sel_e       op_a_sel;
  op_b_sel_e       op_b_sel;
  logic [XLEN-1:0] imm;
  logic            rf_we;
  logic            mac_en;
  logic            illegal;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Sign-extended I-type, zero-filled U-type
  assign imm_i_type = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_u_type = {instr_i[31:12], 12'h000};

  always_comb begin
    alu_op   = ALU_ADD;
    op_a_sel = OP_A_REG_A;
    op_b_sel = OP_B_REG_B;
    imm      = imm_i_type;
    rf_we    = 1'b1;
    mac_en   = 1'b0;
    illegal  = 1'b0;

    case (opcode)
      OPC_OP: begin
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: alu_op = ALU_ADD;
          {7'b0100000, 3'b000}: alu_op = ALU_SUB;
          {7'b0000000, 3'b111}: alu_op = ALU_AND;
          {7'b0000000, 3'b110}: alu_op = ALU_OR;
          {7'b0000000, 3'b100}: alu_op = ALU_XOR;
          // Only MUL of the M extension, low word
          {7'b0000001, 3'b000}: alu_op = ALU_MUL;
          default:              illegal = 1'b1;
        endcase
      end
      OPC_OP_IMM: begin
        // ADDI only
        op_b_sel = OP_B_IMM;
        illegal  = (funct3 != 3'b000);
      end
      OPC_LUI: begin
        // rd = 0 + imm
        op_a_sel = OP_A_ZERO;
        op_b_sel = OP_B_IMM;
        imm      = imm_u_type;
      end
      OPC_CUSTOM0: begin
        // R-type MAC, first cycle multiplies rs1 * rs2
        alu_op  = ALU_MUL;
        mac_en  = (funct7 == 7'b0000000) && (funct3 == 3'b000);
        illegal = !mac_en;
      end
      default: illegal = 1'b1;
    endcase

    // Illegal encodings never write
    if (illegal) begin
      rf_we = 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Qualify everything with the head valid
  //////////////////////////////////////////////////

  assign raddr_a_o  = head_valid_i ? instr_i[19:15] : '0;
  assign raddr_b_o  = head_valid_i ? instr_i[24:20] : '0;
  assign waddr_o    = head_valid_i ? instr_i[11:7]  : '0;
  assign imm_o      = head_valid_i ? imm            : '0;
  assign alu_op_o   = head_valid_i ? alu_op         : ALU_ADD;
  assign op_a_sel_o = head_valid_i ? op_a_sel       : OP_A_REG_A;
  assign op_b_sel_o = head_valid_i ? op_b_sel       : OP_B_REG_B;
  assign rf_we_o    = head_valid_i & rf_we;
  assign mac_en_o   = head_valid_i & mac_en;
  assign illegal_o  = head_valid_i & illegal;

endmodule

//--- verilog/mac_sequencer.sv
//////////////////////////////////////////////////
// ID FSM splitting MAC into multiply then add
// Holds the product, gates write enable and pop
//////////////////////////////////////////////////

`timescale 1ns/1ps

module mac_sequencer (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                head_valid_i,
  input  logic                                mac_en_i,
  input  logic                                illegal_i,
  input  logic                                rf_we_i,
  input  mac_core_pkg::alu_op_e               alu_op_i,
  input  mac_core_pkg::op_b_sel_e             op_b_sel_i,
  input  logic [mac_core_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [mac_core_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [mac_core_pkg::XLEN-1:0]       alu_result_i,
  output mac_core_pkg::alu_op_e               alu_op_o,
  output mac_core_pkg::op_b_sel_e             op_b_sel_o,
  output logic [mac_core_pkg::REG_ADDR_W-1:0] raddr_a_o,
  output logic [mac_core_pkg::XLEN-1:0]       product_o,
  output logic                                rf_we_o,
  output logic                                pop_o,
  output logic                                illegal_insn_o
);

  import mac_core_pkg::*;

  id_fsm_e         id_fsm_q;
  id_fsm_e         id_fsm_d;
  logic            product_we;
  logic [XLEN-1:0] product_q;

  always_comb begin
    // Plain ops pass through and retire in one cycle
    id_fsm_d   = id_fsm_q;
    alu_op_o   = alu_op_i;
    op_b_sel_o = op_b_sel_i;
    raddr_a_o  = raddr_a_i;
    rf_we_o    = rf_we_i;
    pop_o      = head_valid_i;
    product_we = 1'b0;

    case (id_fsm_q)
      FIRST_CYCLE: begin
        if (mac_en_i) begin
          // rs1 * rs2 into the product register, nothing retires yet
          alu_op_o   = ALU_MUL;
          rf_we_o    = 1'b0;
          pop_o      = 1'b0;
          product_we = 1'b1;
          id_fsm_d   = SECOND_CYCLE;
        end
      end
      SECOND_CYCLE: begin
        // Port A now reads rd, so rd + product goes back to rd
        raddr_a_o  = waddr_i;
        op_b_sel_o = OP_B_PRODUCT;
        alu_op_o   = ALU_ADD;
        id_fsm_d   = FIRST_CYCLE;
      end
      default: id_fsm_d = FIRST_CYCLE;
    endcase
  end

  // Illegal retires through the default pop with no write
  assign illegal_insn_o = illegal_i;
  assign product_o      = product_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_fsm_q <= FIRST_CYCLE;
    end else begin
      id_fsm_q <= id_fsm_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (product_we) begin
      product_q <= alu_result_i;
    end
  end

endmodule

//--- verilog/mac_core.sv
//////////////////////////////////////////////////
// Issue-and-execute top level with operand muxes
// Buffer, decoder, MAC FSM, register file, ALU
//////////////////////////////////////////////////

`timescale 1ns/1ps

module mac_core (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                instr_valid_i,
  input  logic [mac_core_pkg::XLEN-1:0]       instr_i,
  output logic                                instr_credit_o,
  output logic                                rf_we_o,
  output logic [mac_core_pkg::REG_ADDR_W-1:0] rf_waddr_o,
  output logic [mac_core_pkg::XLEN-1:0]       rf_wdata_o,
  output logic                                illegal_insn_o
);

  import mac_core_pkg::*;

  // Buffer head
  logic                  head_valid;
  logic [XLEN-1:0]       head_instr;
  logic                  pop;

  // Decoder outputs
  logic [REG_ADDR_W-1:0] dec_raddr_a;
  logic [REG_ADDR_W-1:0] raddr_b;
  logic [REG_ADDR_W-1:0] waddr;
  logic [XLEN-1:0]       imm;
  alu_op_e               dec_alu_op;
  op_a_sel_e             op_a_sel;
  op_b_sel_e             dec_op_b_sel;
  logic                  dec_rf_we;
  logic                  mac_en;
  logic                  dec_illegal;

  // Sequencer outputs
  alu_op_e               alu_op;
  op_b_sel_e             op_b_sel;
  logic [REG_ADDR_W-1:0] raddr_a;
  logic [XLEN-1:0]       product;
  logic                  rf_we;

  // Data path
  logic [XLEN-1:0]       rdata_a;
  logic [XLEN-1:0]       rdata_b;
  logic [XLEN-1:0]       operand_a;
  logic [XLEN-1:0]       operand_b;
  logic [XLEN-1:0]       alu_result;

  instr_buffer i_instr_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (instr_valid_i),
    .push_instr_i (instr_i),
    .pop_i        (pop),
    .head_valid_o (head_valid),
    .head_instr_o (head_instr),
    .credit_o     (instr_credit_o)
  );

  id_decoder i_id_decoder (
    .head_valid_i (head_valid),
    .instr_i      (head_instr),
    .raddr_a_o    (dec_raddr_a),
    .raddr_b_o    (raddr_b),
    .waddr_o      (waddr),
    .imm_o        (imm),
    .alu_op_o     (dec_alu_op),
    .op_a_sel_o   (op_a_sel),
    .op_b_sel_o   (dec_op_b_sel),
    .rf_we_o      (dec_rf_we),
    .mac_en_o     (mac_en),
    .illegal_o    (dec_illegal)
  );

  mac_sequencer i_mac_sequencer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .head_valid_i   (head_valid),
    .mac_en_i       (mac_en),
    .illegal_i      (dec_illegal),
    .rf_we_i        (dec_rf_we),
    .alu_op_i       (dec_alu_op),
    .op_b_sel_i     (dec_op_b_sel),
    .raddr_a_i      (dec_raddr_a),
    .waddr_i        (waddr),
    .alu_result_i   (alu_result),
    .alu_op_o       (alu_op),
    .op_b_sel_o     (op_b_sel),
    .raddr_a_o      (raddr_a),
    .product_o      (product),
    .rf_we_o        (rf_we),
    .pop_o          (pop),
    .illegal_insn_o (illegal_insn_o)
  );

  register_file i_register_file (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (raddr_a),
    .raddr_b_i (raddr_b),
    .waddr_i   (waddr),
    .wdata_i   (alu_result),
    .we_i      (rf_we),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b)
  );

  //////////////////////////////////////////////////
  // Operand muxes
  //////////////////////////////////////////////////

  // Zero for LUI
  assign operand_a = (op_a_sel == OP_A_ZERO) ? '0 : rdata_a;

  always_comb begin
    case (op_b_sel)
      OP_B_IMM:     operand_b = imm;
      // Saved MAC product in the second cycle
      OP_B_PRODUCT: operand_b = product;
      default:      operand_b = rdata_b;
    endcase
  end

  alu i_alu (
    .operator_i  (alu_op),
    .operand_a_i (operand_a),
    .operand_b_i (operand_b),
    .result_o    (alu_result)
  );

  // Write-back port mirrors the register file write
  assign rf_we_o    = rf_we;
  assign rf_waddr_o = waddr;
  assign rf_wdata_o = alu_result;

endmodule

//--- tests/tb_clock_gen.sv
//////////////////////////////////////////////////
// Testbench clock and power-on reset
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release lands a quarter period after an edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #(PERIOD_NS / 4);
    rst_no = 1'b1;
  end

endmodule

//--- tests/tb_mac_core.sv
//////////////////////////////////////////////////
// Table-driven testbench for the MAC issue slice
// Reference register model, LCG section, credits
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_mac_core;

  import mac_core_pkg::*;

  // Run length and stimulus timing
  localparam int          STIM_DELAY       = 2;
  localparam int          RESET_CYCLES     = 10;
  localparam int          CYCLES_PER_ENTRY = 20;
  localparam int          RANDOM_COUNT     = 200;
  localparam logic [31:0] LCG_SEED         = 32'h0113_725c;

  // RV32 major opcodes
  localparam logic [6:0] RV_OP      = 7'h33;
  localparam logic [6:0] RV_OP_IMM  = 7'h13;
  localparam logic [6:0] RV_LUI     = 7'h37;
  localparam logic [6:0] RV_CUSTOM0 = 7'h0b;
  localparam logic [6:0] RV_BRANCH  = 7'h63;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  instr_valid_i;
  logic [XLEN-1:0]       instr_i;
  logic                  instr_credit_o;
  logic                  rf_we_o;
  logic [REG_ADDR_W-1:0] rf_waddr_o;
  logic [XLEN-1:0]       rf_wdata_o;
  logic                  illegal_insn_o;

  // Stimulus table, expected columns come from the model
  string                 tbl_name  [$];
  logic [XLEN-1:0]       tbl_instr [$];
  int                    tbl_gap   [$];
  logic                  tbl_ill   [$];
  logic [REG_ADDR_W-1:0] tbl_waddr [$];
  logic [XLEN-1:0]       tbl_wdata [$];

  // Architectural state of the model
  logic [XLEN-1:0] ref_regs [NUM_REGS];
  logic [31:0]     lcg_state     = LCG_SEED;
  // Table indices in issue order, not yet retired
  int              issued_q [$];
  int              credits       = INSTR_BUF_DEPTH;
  int              credit_pulses = 0;
  int              sent          = 0;
  logic            table_ready   = 1'b0;

  tb_clock_gen #(
    .PERIOD_NS    (40),
    .RESET_CYCLES (RESET_CYCLES)
  ) i_clock_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  mac_core i_mac_core (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .instr_credit_o (instr_credit_o),
    .rf_we_o        (rf_we_o),
    .rf_waddr_o     (rf_waddr_o),
    .rf_wdata_o     (rf_wdata_o),
    .illegal_insn_o (illegal_insn_o)
  );

  task automatic stop_on_error(input string reason);
    $display("%s", reason);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("FAILED %s: expected 0x%08h, actual 0x%08h",
                              name, expected, actual));
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  //////////////////////////////////////////////////
  // Instruction encoders
  //////////////////////////////////////////////////

  function automatic logic [31:0] enc_r(int f7, int f3, int rd, int rs1, int rs2,
                                        logic [6:0] opc);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], RV_OP_IMM};
  endfunction

  function automatic logic [31:0] enc_u(int imm, int rd);
    return {imm[19:0], rd[4:0], RV_LUI};
  endfunction

  // Reference model, runs each entry in issue order
  task automatic add_entry(input string name, input logic [31:0] instr, input int gap);
    logic [4:0]  rd;
    logic [9:0]  funct;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        ill;
    rd    = instr[11:7];
    funct = {instr[31:25], instr[14:12]};
    a     = ref_regs[instr[19:15]];
    b     = ref_regs[instr[24:20]];
    res   = '0;
    ill   = 1'b0;
    case (instr[6:0])
      RV_OP: begin
        // funct7 and funct3 side by side
        case (funct)
          10'h000: res = a + b;
          10'h100: res = a - b;
          10'h007: res = a & b;
          10'h006: res = a | b;
          10'h004: res = a ^ b;
          10'h008: res = a * b;
          default: ill = 1'b1;
        endcase
      end
      RV_OP_IMM: begin
        if (instr[14:12] == 3'b000) begin
          res = a + {{20{instr[31]}}, instr[31:20]};
        end else begin
          ill = 1'b1;
        end
      end
      RV_LUI: res = {instr[31:12], 12'h000};
      RV_CUSTOM0: begin
        // Old rd plus rs1 * rs2
        if (funct == 10'h000) begin
          res = ref_regs[rd] + a * b;
        end else begin
          ill = 1'b1;
        end
      end
      default: ill = 1'b1;
    endcase
    if (!ill && rd != 5'd0) begin
      ref_regs[rd] = res;
    end
    tbl_name.push_back(name);
    tbl_instr.push_back(instr);
    tbl_gap.push_back(gap);
    tbl_ill.push_back(ill);
    tbl_waddr.push_back(rd);
    tbl_wdata.push_back(res);
  endtask

  //////////////////////////////////////////////////
  // Table contents
  //////////////////////////////////////////////////

  task automatic build_table();
    logic [31:0] r;
    logic [31:0] f;
    logic [31:0] instr;
    int          rd;
    int          rs1;
    int          rs2;
    int          gap;
    foreach (ref_regs[i]) begin
      ref_regs[i] = '0;
    end
    // Constants
    add_entry("lui x1", enc_u('h12345, 1), 0);
    add_entry("addi x1", enc_i('h678, 1, 0, 1), 0);
    add_entry("addi x2 minus one", enc_i('hfff, 0, 0, 2), 0);
    add_entry("lui x3", enc_u('h80000, 3), 1);
    add_entry("addi x4", enc_i(7, 0, 0, 4), 0);
    // x0 gets a write-back yet keeps reading zero
    add_entry("addi x0", enc_i(5, 4, 0, 0), 0);
    add_entry("lui x0", enc_u('habcde, 0), 0);
    add_entry("add x5 from x0", enc_r(0, 0, 5, 0, 4, RV_OP), 2);
    // Register ops, wrapped to 32 bits
    add_entry("add wrap", enc_r(0, 0, 6, 1, 2, RV_OP), 0);
    add_entry("sub", enc_r('h20, 0, 7, 4, 1, RV_OP), 0);
    add_entry("and", enc_r(0, 7, 8, 1, 3, RV_OP), 0);
    add_entry("or", enc_r(0, 6, 9, 3, 4, RV_OP), 0);
    add_entry("xor", enc_r(0, 4, 10, 1, 2, RV_OP), 0);
    add_entry("mul negative", enc_r(1, 0, 11, 1, 2, RV_OP), 0);
    add_entry("mul wrap", enc_r(1, 0, 12, 1, 1, RV_OP), 0);
    // MAC, back to back on one rd, then rd equal to rs1
    add_entry("mac x13 first", enc_r(0, 0, 13, 4, 4, RV_CUSTOM0), 0);
    add_entry("mac x13 again", enc_r(0, 0, 13, 4, 4, RV_CUSTOM0), 0);
    add_entry("mac x13 big", enc_r(0, 0, 13, 1, 4, RV_CUSTOM0), 0);
    add_entry("mac rd is rs1", enc_r(0, 0, 4, 4, 2, RV_CUSTOM0), 0);
    add_entry("add after mac", enc_r(0, 0, 15, 13, 4, RV_OP), 3);
    // Illegal encodings, no write but a credit back
    add_entry("illegal zero", 32'h0000_0000, 0);
    add_entry("illegal alt and", enc_r('h20, 7, 5, 1, 1, RV_OP), 0);
    add_entry("illegal slti", enc_i(3, 1, 2, 5), 0);
    add_entry("illegal mac f3", enc_r(0, 1, 13, 1, 1, RV_CUSTOM0), 0);
    add_entry("illegal branch", 32'h0020_8063, 0);
    add_entry("illegal ones", 32'hffff_ffff, 1);
    // Burst that fills the buffer
    for (int k = 0; k < 8; k++) begin
      add_entry($sformatf("burst mac %0d", k), enc_r(0, 0, 16, k + 1, 2, RV_CUSTOM0), 0);
      if (k % 3 == 2) begin
        add_entry($sformatf("burst illegal %0d", k), 32'h0000_0000, 0);
      end
    end
    add_entry("read x16", enc_r(0, 0, 17, 16, 0, RV_OP), 0);
    // LCG section, codes 10 to 13 are MAC
    // Low LCG bits repeat quickly, so fields come from the upper bits
    for (int k = 0; k < RANDOM_COUNT; k++) begin
      r   = lcg_next();
      f   = lcg_next();
      gap = (r[26:25] == 2'b00) ? int'(r[24:23]) : 0;
      rd  = int'(f[31:27]);
      rs1 = int'(f[26:22]);
      rs2 = int'(f[21:17]);
      case (int'(r[31:28]))
        0:       instr = enc_r(0, 0, rd, rs1, rs2, RV_OP);
        1:       instr = enc_r('h20, 0, rd, rs1, rs2, RV_OP);
        2:       instr = enc_r(0, 7, rd, rs1, rs2, RV_OP);
        3:       instr = enc_r(0, 6, rd, rs1, rs2, RV_OP);
        4:       instr = enc_r(0, 4, rd, rs1, rs2, RV_OP);
        5:       instr = enc_r(1, 0, rd, rs1, rs2, RV_OP);
        6, 7:    instr = enc_i(int'(r[22:11]), rs1, 0, rd);
        8, 9:    instr = enc_u(int'(f[31:12]), rd);
        14:      instr = r[27] ? enc_r('h7f, int'(f[17:15]), rd, rs1, rs2, RV_OP)
                               : {f[31:7], RV_BRANCH};
        15:      instr = r[27] ? enc_i(int'(r[22:11]), rs1, int'(f[17:15]) | 1, rd)
                               : enc_r(1, 0, rd, rs1, rs2, RV_CUSTOM0);
        default: instr = enc_r(0, 0, rd, rs1, rs2, RV_CUSTOM0);
      endcase
      add_entry($sformatf("random %0d", k), instr, gap);
    end
  endtask

  //////////////////////////////////////////////////
  // Monitor, sampled mid-cycle
  //////////////////////////////////////////////////

  always @(negedge clk_i) begin : monitor
    int idx;
    if (rst_ni) begin
      if (instr_credit_o) begin
        credits++;
        credit_pulses++;
      end
      if (rf_we_o || illegal_insn_o) begin
        if (issued_q.size() == 0) begin
          stop_on_error("Write-back or illegal flag seen with nothing outstanding");
        end else begin
          idx = issued_q.pop_front();
          check_value({tbl_name[idx], " illegal"}, 32'(tbl_ill[idx]), 32'(illegal_insn_o));
          check_value({tbl_name[idx], " write enable"}, 32'(!tbl_ill[idx]), 32'(rf_we_o));
          check_value({tbl_name[idx], " credit"}, 32'd1, 32'(instr_credit_o));
          if (!tbl_ill[idx]) begin
            check_value({tbl_name[idx], " waddr"}, 32'(tbl_waddr[idx]), 32'(rf_waddr_o));
            check_value({tbl_name[idx], " wdata"}, tbl_wdata[idx], rf_wdata_o);
          end
        end
      end
    end
  end

  // Budget scales with the table length
  initial begin : watchdog
    wait (table_ready);
    repeat (RESET_CYCLES + CYCLES_PER_ENTRY * tbl_instr.size()) @(posedge clk_i);
    stop_on_error("Timeout: instructions stopped retiring before the table finished");
  end

  initial begin : driver
    int idx;
    int gap_left;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    build_table();
    table_ready = 1'b1;
    idx         = 0;
    gap_left    = tbl_gap[0];
    @(posedge rst_ni);
    @(negedge clk_i);
    check_value("reset credit", 32'd0, 32'(instr_credit_o));
    check_value("reset write enable", 32'd0, 32'(rf_we_o));
    check_value("reset illegal", 32'd0, 32'(illegal_insn_o));
    // Send only while holding a credit
    while (idx < tbl_instr.size()) begin
      @(posedge clk_i);
      #STIM_DELAY;
      instr_valid_i = 1'b0;
      if (gap_left > 0) begin
        gap_left--;
      end else if (credits > 0) begin
        instr_valid_i = 1'b1;
        instr_i       = tbl_instr[idx];
        credits--;
        sent++;
        issued_q.push_back(idx);
        if (issued_q.size() > INSTR_BUF_DEPTH) begin
          stop_on_error("More instructions outstanding than buffer entries");
        end
        idx++;
        if (idx < tbl_instr.size()) begin
          gap_left = tbl_gap[idx];
        end
      end
    end
    @(posedge clk_i);
    #STIM_DELAY;
    instr_valid_i = 1'b0;
    while (issued_q.size() != 0) begin
      @(posedge clk_i);
    end
    repeat (4) @(posedge clk_i);
    check_value("credit pulses against sent", sent, credit_pulses);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- mac_core.f
verilog/mac_core_pkg.sv
verilog/alu.sv
verilog/register_file.sv
verilog/instr_buffer.sv
verilog/id_decoder.sv
verilog/mac_sequencer.sv
verilog/mac_core.sv
tests/tb_clock_gen.sv
tests/tb_mac_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the MAC core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module tb_mac_core -f mac_core.f

# A failing run exits nonzero, so the result comes from the printed lines
output=$(./obj_dir/Vtb_mac_core 2>&1 || true)
echo "$output"

if echo "$output" | grep -qx "TEST RESULT: PASS"; then
  exit 0
else
  exit 1
fi
